//--- include/smAlu_macros.svh
`ifndef SM_ALU_MACROS_SVH
`define SM_ALU_MACROS_SVH

// magnitude bits of a number, the sign bit sits above them.
`define SM_MAG_WIDTH 15

// tags count modulo 2**width.
`define SM_TAG_WIDTH 4

// command queue entries, a power of two.
`define SM_FIFO_DEPTH 4

`endif

//--- verilog/smNumberPkg.sv
`default_nettype none

`include "smAlu_macros.svh"

package smNumberPkg;

	// sign set means negative.
	typedef struct packed {
		logic sign;
		logic [`SM_MAG_WIDTH-1:0] mag;
	} smNumber_t;

	// overflow marks a same-sign carry out of the magnitude.
	typedef struct packed {
		smNumber_t value;
		logic [`SM_TAG_WIDTH-1:0] tag;
		logic overflow;
	} smResult_t;

endpackage

`default_nettype wire

//--- verilog/smInstrPkg.sv
`default_nettype none

`include "smAlu_macros.svh"

package smInstrPkg;

	import smNumberPkg::*;

	typedef enum logic {
		KIND_PAIR = 1'b0,
		KIND_IMM  = 1'b1
	} smKind_e;

	typedef struct packed {
		smNumber_t a;
		smNumber_t b;
	} smPairView_t;

	// operand b is immSign with immMag shifted left by shift.
	typedef struct packed {
		smNumber_t a;
		logic [4:0] pad;
		logic [2:0] shift;
		logic immSign;
		logic [6:0] immMag;
	} smImmView_t;

	typedef union packed {
		smPairView_t pair;
		smImmView_t imm;
	} smPayload_u;

	typedef struct packed {
		smKind_e kind;
		logic sub;
		smPayload_u payload;
	} smInstr_t;

	typedef struct packed {
		smNumber_t a;
		smNumber_t b;
		logic sub;
		logic [`SM_TAG_WIDTH-1:0] tag;
	} smCmd_t;

endpackage

`default_nettype wire

//--- verilog/smInstrDecode.sv
`default_nettype none

`include "smAlu_macros.svh"

module smInstrDecode (
	input logic clk,
	input logic nRST,
	input logic instrValid,
	input smInstrPkg::smInstr_t instr,
	input logic full,
	output logic push,
	output smInstrPkg::smCmd_t cmd
);

	import smInstrPkg::*;

	logic [`SM_TAG_WIDTH-1:0] tagCount;
	logic [`SM_MAG_WIDTH-1:0] immExt;

	// a strobe while the queue is full is simply lost.
	assign push = instrValid & ~full;

	assign immExt = {{(`SM_MAG_WIDTH - 7){1'b0}}, instr.payload.imm.immMag};

	always_comb begin
		// operand a sits in the same bits in both views.
		cmd.a = instr.payload.pair.a;
		cmd.sub = instr.sub;
		cmd.tag = tagCount;
		if (instr.kind == KIND_IMM) begin
			cmd.b.sign = instr.payload.imm.immSign;
			// 127 << 7 still fits in the magnitude.
			cmd.b.mag = immExt << instr.payload.imm.shift;
		end else begin
			cmd.b = instr.payload.pair.b;
		end
	end

	// tag advances on accepted instructions only.
	always_ff @(posedge clk, negedge nRST) begin
		if (!nRST) begin
			tagCount <= '0;
		end else if (push) begin
			tagCount <= tagCount + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/smCmdFifo.sv
`default_nettype none

`include "smAlu_macros.svh"

module smCmdFifo (
	input logic clk,
	input logic nRST,
	input logic push,
	input smInstrPkg::smCmd_t cmdIn,
	input logic pop,
	output smInstrPkg::smCmd_t head,
	output logic notEmpty,
	output logic full
);

	import smInstrPkg::*;

	localparam int PTR_W = $clog2(`SM_FIFO_DEPTH);

	smCmd_t mem [`SM_FIFO_DEPTH];

	// one extra bit tells a full queue from an empty one.
	logic [PTR_W:0] wrPtr;
	logic [PTR_W:0] rdPtr;
	logic [PTR_W:0] wrNext;
	logic [PTR_W:0] rdNext;
	logic pushOk;
	logic popOk;

	assign pushOk = push & ~full;
	assign popOk = pop & notEmpty;

	assign wrNext = pushOk ? wrPtr + 1'b1 : wrPtr;
	assign rdNext = popOk ? rdPtr + 1'b1 : rdPtr;

	assign notEmpty = (wrPtr != rdPtr);
	assign head = mem[rdPtr[PTR_W-1:0]];

	always_ff @(posedge clk, negedge nRST) begin
		if (!nRST) begin
			wrPtr <= '0;
			rdPtr <= '0;
			full <= 1'b0;
		end else begin
			wrPtr <= wrNext;
			rdPtr <= rdNext;
			// full when the pointers differ only in the wrap bit.
			full <= (wrNext[PTR_W] != rdNext[PTR_W]) &&
				(wrNext[PTR_W-1:0] == rdNext[PTR_W-1:0]);
		end
	end

	always_ff @(posedge clk) begin
		if (pushOk) begin
			mem[wrPtr[PTR_W-1:0]] <= cmdIn;
		end
	end

endmodule

`default_nettype wire

//--- verilog/smRippleAdder15.sv
`default_nettype none

`include "smAlu_macros.svh"

module smRippleAdder15 (
	input logic [`SM_MAG_WIDTH-1:0] in1,
	input logic [`SM_MAG_WIDTH-1:0] in2,
	input logic sub,
	output logic [`SM_MAG_WIDTH-1:0] sum,
	output logic cOut
);

	// subtract is in1 plus the inverted in2 plus one.
	for (genvar i = 0; i < `SM_MAG_WIDTH; i++) begin : bitCell
		logic cIn;
		logic bIn;
		logic cO;

		if (i == 0) begin : firstCarry
			assign cIn = sub;
		end else begin : chainCarry
			assign cIn = bitCell[i-1].cO;
		end

		assign bIn = in2[i] ^ sub;
		assign sum[i] = in1[i] ^ bIn ^ cIn;
		assign cO = (in1[i] & bIn) | (bIn & cIn) | (cIn & in1[i]);
	end

	assign cOut = bitCell[`SM_MAG_WIDTH-1].cO;

endmodule

`default_nettype wire

//--- verilog/smAddEngine.sv
`default_nettype none

`include "smAlu_macros.svh"

module smAddEngine (
	input logic clk,
	input logic nRST,
	input logic notEmpty,
	input smInstrPkg::smCmd_t head,
	output logic pop,
	output logic resValid,
	output smNumberPkg::smResult_t result
);

	import smInstrPkg::*;

	typedef enum logic [1:0] {
		IDLE,
		SET,
		ADD,
		FIN
	} state_t;

	state_t state;
	state_t next;

	smCmd_t cmdQ;

	logic [`SM_MAG_WIDTH-1:0] n1;
	logic [`SM_MAG_WIDTH-1:0] n2;
	logic diffSign;
	logic sameSignVal;

	logic effSignB;
	logic signsDiffer;

	logic [`SM_MAG_WIDTH-1:0] adderOut;
	logic adderCOut;
	logic [`SM_MAG_WIDTH-1:0] comp;

	assign pop = (state == IDLE) & notEmpty;
	assign resValid = (state == FIN);

	// subtraction flips the sign of b.
	assign effSignB = cmdQ.b.sign ^ cmdQ.sub;
	assign signsDiffer = cmdQ.a.sign ^ effSignB;

	always_comb begin
		next = state;
		case (state)
			IDLE: if (notEmpty) next = SET;
			SET: next = ADD;
			ADD: next = FIN;
			FIN: next = IDLE;
			default: next = IDLE;
		endcase
	end

	always_ff @(posedge clk, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
		end else begin
			state <= next;
		end
	end

	smRippleAdder15 mainAdder (
		.in1(n1),
		.in2(n2),
		.sub(diffSign),
		.sum(adderOut),
		.cOut(adderCOut)
	);

	// zero minus the difference, used when the difference went negative.
	smRippleAdder15 compAdder (
		.in1('0),
		.in2(adderOut),
		.sub(1'b1),
		.sum(comp),
		.cOut()
	);

	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (notEmpty) cmdQ <= head;
			end
			SET: begin
				diffSign <= signsDiffer;
				sameSignVal <= cmdQ.a.sign;
				// positive magnitude is the minuend.
				if (signsDiffer && cmdQ.a.sign) begin
					n1 <= cmdQ.b.mag;
					n2 <= cmdQ.a.mag;
				end else begin
					n1 <= cmdQ.a.mag;
					n2 <= cmdQ.b.mag;
				end
			end
			ADD: begin
				result.tag <= cmdQ.tag;
				if (!diffSign) begin
					result.value.sign <= sameSignVal;
					result.value.mag <= adderOut;
					result.overflow <= adderCOut;
				end else if (adderCOut) begin
					// equal magnitudes land here as positive zero.
					result.value.sign <= 1'b0;
					result.value.mag <= adderOut;
					result.overflow <= 1'b0;
				end else begin
					result.value.sign <= 1'b1;
					result.value.mag <= comp;
					result.overflow <= 1'b0;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/smAluTop.sv
`default_nettype none

module smAluTop (
	input logic clk,
	input logic nRST,
	input logic instrValid,
	input smInstrPkg::smInstr_t instr,
	output logic full,
	output logic resValid,
	output smNumberPkg::smResult_t result
);

	import smInstrPkg::*;

	logic push;
	smCmd_t cmd;
	logic pop;
	smCmd_t head;
	logic notEmpty;

	smInstrDecode decodeInst (
		.clk(clk),
		.nRST(nRST),
		.instrValid(instrValid),
		.instr(instr),
		.full(full),
		.push(push),
		.cmd(cmd)
	);

	smCmdFifo fifoInst (
		.clk(clk),
		.nRST(nRST),
		.push(push),
		.cmdIn(cmd),
		.pop(pop),
		.head(head),
		.notEmpty(notEmpty),
		.full(full)
	);

	smAddEngine engineInst (
		.clk(clk),
		.nRST(nRST),
		.notEmpty(notEmpty),
		.head(head),
		.pop(pop),
		.resValid(resValid),
		.result(result)
	);

endmodule

`default_nettype wire

//--- bench/smAluBench.sv
`default_nettype none

`include "smAlu_macros.svh"

module smAluBench;

	import smNumberPkg::*;
	import smInstrPkg::*;

	localparam int N_RAND = 16;
	localparam int N_IMM = 24;
	localparam int N_TAG = 20;
	localparam int N_BP = 16;
	// directed cases plus the mid-run reset instructions.
	localparam int TOTAL_INSTR = 4 + N_RAND + 5 + N_RAND + 1 + N_IMM + N_TAG + N_BP + 4;
	localparam int TIMEOUT = TOTAL_INSTR * 4 * 8 + 200 * 8;

	logic clk;
	logic nRST;
	logic instrValid;
	smInstr_t instr;
	logic full;
	logic resValid;
	smResult_t result;

	logic [16:0] lfsrState;
	logic [`SM_TAG_WIDTH-1:0] tagCount;
	smResult_t expQ[$];
	string nameQ[$];
	int valueErrors = 0;
	int otherErrors = 0;
	int checked = 0;
	int dropped = 0;

	smAluTop smAluTop_inst (
		.clk(clk),
		.nRST(nRST),
		.instrValid(instrValid),
		.instr(instr),
		.full(full),
		.resValid(resValid),
		.result(result)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// 17-bit Fibonacci LFSR with taps at bits 17 and 14.
	function automatic logic lfsrBit();
		logic fb;
		fb = lfsrState[16] ^ lfsrState[13];
		lfsrState = {lfsrState[15:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] randBits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[6:0], lfsrBit()};
		end
		return v;
	endfunction

	function automatic smNumber_t randNumber();
		smNumber_t v;
		v.sign = lfsrBit();
		for (int i = 0; i < `SM_MAG_WIDTH; i++) begin
			v.mag[i] = lfsrBit();
		end
		return v;
	endfunction

	function automatic smNumber_t num(input logic sign, input logic [`SM_MAG_WIDTH-1:0] mag);
		smNumber_t v;
		v.sign = sign;
		v.mag = mag;
		return v;
	endfunction

	function automatic smInstr_t makePair(input logic sub, input smNumber_t a, input smNumber_t b);
		smInstr_t ins;
		ins.kind = KIND_PAIR;
		ins.sub = sub;
		ins.payload.pair.a = a;
		ins.payload.pair.b = b;
		return ins;
	endfunction

	function automatic smInstr_t makeImm(input logic sub, input smNumber_t a, input logic immSign,
		input logic [6:0] immMag, input logic [2:0] shift);
		smInstr_t ins;
		ins.kind = KIND_IMM;
		ins.sub = sub;
		ins.payload.imm.a = a;
		ins.payload.imm.pad = '0;
		ins.payload.imm.shift = shift;
		ins.payload.imm.immSign = immSign;
		ins.payload.imm.immMag = immMag;
		return ins;
	endfunction

	// expands an instruction into the operands the engine should see.
	function automatic smCmd_t toCommand(input smInstr_t ins, input logic [`SM_TAG_WIDTH-1:0] tag);
		smCmd_t c;
		logic [`SM_MAG_WIDTH-1:0] m;
		// operand a has the same place in both payload views.
		c.a = ins.payload.pair.a;
		c.sub = ins.sub;
		c.tag = tag;
		if (ins.kind == KIND_IMM) begin
			m = '0;
			m[6:0] = ins.payload.imm.immMag;
			c.b.sign = ins.payload.imm.immSign;
			c.b.mag = m << ins.payload.imm.shift;
		end else begin
			c.b = ins.payload.pair.b;
		end
		return c;
	endfunction

	function automatic smResult_t refResult(input smCmd_t c);
		smResult_t r;
		logic signB;
		logic [`SM_MAG_WIDTH:0] total;
		logic [`SM_MAG_WIDTH-1:0] posMag;
		logic [`SM_MAG_WIDTH-1:0] negMag;
		signB = c.b.sign ^ c.sub;
		r.tag = c.tag;
		r.overflow = 1'b0;
		if (c.a.sign == signB) begin
			// carry out of the magnitude is flagged and negative zero stays.
			total = {1'b0, c.a.mag} + {1'b0, c.b.mag};
			r.value.sign = c.a.sign;
			r.value.mag = total[`SM_MAG_WIDTH-1:0];
			r.overflow = total[`SM_MAG_WIDTH];
		end else begin
			posMag = c.a.sign ? c.b.mag : c.a.mag;
			negMag = c.a.sign ? c.a.mag : c.b.mag;
			if (posMag >= negMag) begin
				r.value.sign = 1'b0;
				r.value.mag = posMag - negMag;
			end else begin
				r.value.sign = 1'b1;
				r.value.mag = negMag - posMag;
			end
		end
		return r;
	endfunction

	function automatic string fmtResult(input smResult_t r);
		return $sformatf("sign=%0b mag=%0d tag=%0d ovf=%0b",
			r.value.sign, r.value.mag, r.tag, r.overflow);
	endfunction

	task automatic checkResult(input string name, input smResult_t exp, input smResult_t act);
		if (act !== exp) begin
			valueErrors++;
			$display("** Error %s: expected %s, actual %s", name, fmtResult(exp), fmtResult(act));
		end
	endtask

	task automatic checkFull(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			valueErrors++;
			$display("** Error %s: expected full=%0b, actual full=%0b", name, exp, act);
		end
	endtask

	// an instruction strobed on a falling edge counts only if full is low.
	task automatic strobe(input string name, input smInstr_t ins);
		instr = ins;
		instrValid = 1'b1;
		if (!full) begin
			expQ.push_back(refResult(toCommand(ins, tagCount)));
			nameQ.push_back(name);
			tagCount = tagCount + 1'b1;
		end else begin
			dropped++;
		end
		@(negedge clk);
		instrValid = 1'b0;
	endtask

	task automatic sendPaced(input string name, input smInstr_t ins);
		while (full) begin
			@(negedge clk);
		end
		strobe(name, ins);
	endtask

	task automatic drain();
		while (expQ.size() != 0) begin
			@(negedge clk);
		end
		@(negedge clk);
	endtask

	task automatic backPressure();
		logic sawFull;
		int dropsBefore;
		sawFull = 1'b0;
		dropsBefore = dropped;
		for (int i = 0; i < N_BP; i++) begin
			if (full) begin
				sawFull = 1'b1;
			end
			strobe("backPressure", makePair(lfsrBit(), randNumber(), randNumber()));
		end
		if (!sawFull || dropped == dropsBefore) begin
			otherErrors++;
			$display("full never rose while an instruction was strobed every cycle");
		end
		drain();
		checkFull("backPressure", 1'b0, full);
	endtask

	task automatic resetMidRun();
		int flushed;
		for (int i = 0; i < 3; i++) begin
			strobe("midReset", makePair(lfsrBit(), randNumber(), randNumber()));
		end
		repeat (2) @(negedge clk);
		while (resValid) begin
			@(negedge clk);
		end
		nRST = 1'b0;
		flushed = expQ.size();
		expQ.delete();
		nameQ.delete();
		tagCount = '0;
		if (flushed == 0) begin
			otherErrors++;
			$display("no results were pending when the mid-run reset was applied");
		end
		repeat (4) begin
			@(negedge clk);
			if (resValid) begin
				otherErrors++;
				$display("resValid was high while reset was held");
			end
			checkFull("midReset", 1'b0, full);
		end
		nRST = 1'b1;
		repeat (3) @(negedge clk);
		checkFull("midReset", 1'b0, full);
		// first result after reset must carry tag 0.
		strobe("midReset", makePair(1'b0, num(1'b0, 15'd1234), num(1'b1, 15'd34)));
		drain();
	endtask

	always @(negedge clk) begin : compareResults
		smResult_t expRes;
		string expName;
		if (nRST && resValid) begin
			if (expQ.size() == 0) begin
				otherErrors++;
				$display("a result with tag %0d arrived while no result was expected", result.tag);
			end else begin
				expRes = expQ.pop_front();
				expName = nameQ.pop_front();
				checked++;
				checkResult(expName, expRes, result);
			end
		end
	end

	initial begin : watchdog
		#(TIMEOUT);
		$display("timeout after %0d time units with %0d results still pending",
			TIMEOUT, expQ.size());
		$display("tests failed");
		$finish;
	end

	initial begin
		nRST = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		tagCount = '0;
		lfsrState = 17'd86371;
		repeat (4) @(negedge clk);
		nRST = 1'b1;
		@(negedge clk);
		checkFull("reset", 1'b0, full);

		sendPaced("sameSign", makePair(1'b0, num(1'b0, 15'd100), num(1'b0, 15'd200)));
		sendPaced("sameSign", makePair(1'b0, num(1'b1, 15'h7fff), num(1'b1, 15'd1)));
		sendPaced("sameSign", makePair(1'b0, num(1'b0, 15'h7fff), num(1'b0, 15'h7fff)));
		sendPaced("sameSign", makePair(1'b0, num(1'b0, 15'd0), num(1'b0, 15'd0)));
		for (int i = 0; i < N_RAND; i++) begin
			smNumber_t a;
			smNumber_t b;
			a = randNumber();
			b = randNumber();
			b.sign = a.sign;
			sendPaced("sameSign", makePair(1'b0, a, b));
		end
		drain();

		sendPaced("mixedSign", makePair(1'b0, num(1'b0, 15'd5), num(1'b1, 15'd5)));
		sendPaced("mixedSign", makePair(1'b1, num(1'b0, 15'd5), num(1'b0, 15'd5)));
		sendPaced("mixedSign", makePair(1'b1, num(1'b1, 15'd5), num(1'b1, 15'd5)));
		sendPaced("mixedSign", makePair(1'b0, num(1'b0, 15'd3), num(1'b1, 15'd10)));
		sendPaced("mixedSign", makePair(1'b1, num(1'b1, 15'd10), num(1'b1, 15'd3)));
		for (int i = 0; i < N_RAND; i++) begin
			sendPaced("mixedSign", makePair(lfsrBit(), randNumber(), randNumber()));
		end
		drain();

		// largest immediate operand is 127 shifted by 7.
		sendPaced("immediate", makeImm(1'b0, num(1'b0, 15'd0), 1'b0, 7'd127, 3'd7));
		for (int i = 0; i < N_IMM; i++) begin
			sendPaced("immediate", makeImm(lfsrBit(), randNumber(), lfsrBit(),
				7'(randBits(7)), 3'(randBits(3))));
		end
		drain();

		for (int i = 0; i < N_TAG; i++) begin
			if (lfsrBit()) begin
				sendPaced("tagOrder", makeImm(lfsrBit(), randNumber(), lfsrBit(),
					7'(randBits(7)), 3'(randBits(3))));
			end else begin
				sendPaced("tagOrder", makePair(lfsrBit(), randNumber(), randNumber()));
			end
		end
		drain();

		backPressure();
		resetMidRun();

		$display("checked %0d results, dropped %0d strobes, %0d value errors, %0d other errors",
			checked, dropped, valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
verilog/smNumberPkg.sv
verilog/smInstrPkg.sv
verilog/smInstrDecode.sv
verilog/smCmdFifo.sv
verilog/smRippleAdder15.sv
verilog/smAddEngine.sv
verilog/smAluTop.sv
bench/smAluBench.sv

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module smAluBench -Mdir obj_dir -o smAluBench
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/smAluBench)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
	exit 0
fi
exit 1
